// ==== files.f ====
hdl/mem_pkg.sv
hdl/mem_dtlb.sv
hdl/mem_data_ram.sv
hdl/mem_pipe.sv
hdl/mem_subsystem_top.sv
verification/mem_tb.sv

// ==== hdl/mem_data_ram.sv ====
/*
  Single-port byte-enabled scratchpad, one access per cycle.
  Read data arrives one cycle after v_i and holds until the next read.
*/
`timescale 1ns/1ns

module mem_data_ram
  import mem_pkg::*;
  (input                        clk_i
   , input                      reset_i

   , input                      v_i
   , input                      we_i
   , input [RAM_ADDR_W-1:0]     addr_i
   , input [7:0]                be_i
   , input [DWORD_W-1:0]        wdata_i

   , output logic [DWORD_W-1:0] rdata_o
   );

  logic [DWORD_W-1:0] mem_r [RAM_WORDS];

  logic write_en, read_en;

  assign write_en = v_i & we_i;
  assign read_en  = v_i & ~we_i;

  // One write enable per byte lane
  for (genvar b = 0; b < 8; b++) begin : g_lane
    always_ff @(posedge clk_i) begin
      if (write_en && be_i[b]) begin
        mem_r[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_o <= '0;
    end else if (read_en) begin
      rdata_o <= mem_r[addr_i];
    end
  end

endmodule

// ==== hdl/mem_dtlb.sv ====
/*
  Fully associative data TLB with combinational lookup.
  A fill with a vtag already present overwrites that entry; flush wins over fill.
*/
`timescale 1ns/1ns

module mem_dtlb
  import mem_pkg::*;
  #(parameter int els_p = TLB_ELS)
  (input                       clk_i
   , input                     reset_i
   , input                     flush_i

   , input                     lookup_v_i
   , input [VTAG_W-1:0]        lookup_vtag_i

   , input                     fill_v_i
   , input [VTAG_W-1:0]        fill_vtag_i
   , input [PTAG_W-1:0]        fill_ptag_i
   , input                     fill_r_i
   , input                     fill_w_i
   , input                     fill_u_i
   , input                     fill_d_i

   , output logic              hit_o
   , output logic [PTAG_W-1:0] ptag_o
   , output logic              r_o
   , output logic              w_o
   , output logic              u_o
   , output logic              d_o
   );

  localparam int idx_w_lp = (els_p > 1) ? $clog2(els_p) : 1;

  logic [els_p-1:0]    valid_r;
  logic [VTAG_W-1:0]   vtag_r [els_p];
  logic [PTAG_W-1:0]   ptag_r [els_p];
  logic [els_p-1:0]    r_r, w_r, u_r, d_r;
  logic [idx_w_lp-1:0] rr_ptr_r;

  logic [els_p-1:0]    lookup_match, fill_match;
  logic                fill_hit, have_free;
  logic [idx_w_lp-1:0] fill_hit_idx, free_idx, fill_idx;

  always_comb begin
    for (int i = 0; i < els_p; i++) begin
      lookup_match[i] = valid_r[i] & (vtag_r[i] == lookup_vtag_i);
      fill_match[i]   = valid_r[i] & (vtag_r[i] == fill_vtag_i);
    end
  end

  assign hit_o = lookup_v_i & (|lookup_match);

  // At most one entry matches a given vtag
  always_comb begin
    ptag_o = '0;
    r_o    = 1'b0;
    w_o    = 1'b0;
    u_o    = 1'b0;
    d_o    = 1'b0;
    for (int i = 0; i < els_p; i++) begin
      if (lookup_match[i]) begin
        ptag_o = ptag_r[i];
        r_o    = r_r[i];
        w_o    = w_r[i];
        u_o    = u_r[i];
        d_o    = d_r[i];
      end
    end
  end

  // Descending scan leaves the lowest matching or free index
  always_comb begin
    fill_hit     = 1'b0;
    fill_hit_idx = '0;
    have_free    = 1'b0;
    free_idx     = '0;
    for (int i = els_p - 1; i >= 0; i--) begin
      if (fill_match[i]) begin
        fill_hit     = 1'b1;
        fill_hit_idx = idx_w_lp'(i);
      end
      if (!valid_r[i]) begin
        have_free = 1'b1;
        free_idx  = idx_w_lp'(i);
      end
    end
    fill_idx = fill_hit ? fill_hit_idx : (have_free ? free_idx : rr_ptr_r);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      rr_ptr_r <= '0;
    end else if (flush_i) begin
      valid_r <= '0;
    end else if (fill_v_i) begin
      valid_r[fill_idx] <= 1'b1;
      // Victim pointer only moves when it was used
      if (!fill_hit && !have_free) begin
        rr_ptr_r <= (rr_ptr_r == idx_w_lp'(els_p - 1)) ? '0 : rr_ptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      vtag_r[fill_idx] <= fill_vtag_i;
      ptag_r[fill_idx] <= fill_ptag_i;
      r_r[fill_idx]    <= fill_r_i;
      w_r[fill_idx]    <= fill_w_i;
      u_r[fill_idx]    <= fill_u_i;
      d_r[fill_idx]    <= fill_d_i;
    end
  end

endmodule

// ==== hdl/mem_pipe.sv ====
/*
  Two-stage load/store pipe, one request per cycle, results two cycles after accept.
  Results cannot stall; req_ready_o drops only while a TLB fill is written.
*/
`timescale 1ns/1ns

module mem_pipe
  import mem_pkg::*;
  (input                        clk_i
   , input                      reset_i

   , input                      req_v_i
   , output logic               req_ready_o
   , input mem_op_e             req_op_i
   , input [DWORD_W-1:0]        req_rs1_i
   , input [DWORD_W-1:0]        req_imm_i
   , input [DWORD_W-1:0]        req_rs2_i

   , input                      tlb_fill_v_i
   , input                      translation_en_i
   , input priv_mode_e          priv_mode_i
   , input                      sum_i

   , output logic               tlb_lookup_v_o
   , output logic [VTAG_W-1:0]  tlb_lookup_vtag_o
   , input                      tlb_hit_i
   , input [PTAG_W-1:0]         tlb_ptag_i
   , input                      tlb_r_i
   , input                      tlb_w_i
   , input                      tlb_u_i
   , input                      tlb_d_i

   , output logic               ram_v_o
   , output logic               ram_we_o
   , output logic [RAM_ADDR_W-1:0] ram_addr_o
   , output logic [7:0]         ram_be_o
   , output logic [DWORD_W-1:0] ram_wdata_o
   , input [DWORD_W-1:0]        ram_rdata_i

   , output logic               result_v_o
   , output logic [DWORD_W-1:0] result_data_o
   , output logic [VADDR_W-1:0] result_vaddr_o

   , output logic               tlb_miss_o
   , output logic               load_page_fault_o
   , output logic               store_page_fault_o
   , output logic               load_access_fault_o
   , output logic               store_access_fault_o
   , output logic               load_misaligned_o
   , output logic               store_misaligned_o
   );

  localparam int paddr_w_lp = PTAG_W + PAGE_OFFSET_W;
  localparam int pad_w_lp   = DWORD_W - VADDR_W;

  logic accept;
  logic [DWORD_W-1:0] eaddr;

  logic               s1_v_r;
  mem_op_e            s1_op_r;
  logic [DWORD_W-1:0] s1_eaddr_r;
  logic [DWORD_W-1:0] s1_wdata_r;

  logic s1_store, mis_raw, noncanon, priv_fault;
  logic misaligned, bad_addr, tlb_miss, xlate_ok;
  logic perm_fault, range_fault, page_fault, access_fault;
  logic [PTAG_W-1:0]     s1_ptag;
  logic [paddr_w_lp-1:0] s1_paddr;
  logic [7:0]            base_be;
  logic [6:0]            s1_flags;

  logic               s2_v_r;
  mem_op_e            s2_op_r;
  logic [2:0]         s2_off_r;
  logic [VADDR_W-1:0] s2_vaddr_r;
  logic [6:0]         s2_flags_r;

  logic               load_ok;
  logic [DWORD_W-1:0] lane, load_data;
  logic [6:0]         res_flags_r;

  assign req_ready_o = ~tlb_fill_v_i;
  assign accept      = req_v_i & req_ready_o;
  assign eaddr       = req_rs1_i + req_imm_i;

  // Stage 0 capture
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_r <= 1'b0;
    end else begin
      s1_v_r <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      s1_op_r    <= req_op_i;
      s1_eaddr_r <= eaddr;
      s1_wdata_r <= req_rs2_i;
    end
  end

  assign tlb_lookup_v_o    = s1_v_r & translation_en_i;
  assign tlb_lookup_vtag_o = s1_eaddr_r[PAGE_OFFSET_W +: VTAG_W];

  assign s1_store = op_is_store(s1_op_r);
  assign noncanon = s1_eaddr_r[DWORD_W-1:VADDR_W] != {pad_w_lp{s1_eaddr_r[VADDR_W-1]}};

  always_comb begin
    case (op_size_log2(s1_op_r))
      2'd0: begin
        base_be = 8'h01;
        mis_raw = 1'b0;
      end
      2'd1: begin
        base_be = 8'h03;
        mis_raw = s1_eaddr_r[0];
      end
      2'd2: begin
        base_be = 8'h0f;
        mis_raw = |s1_eaddr_r[1:0];
      end
      default: begin
        base_be = 8'hff;
        mis_raw = |s1_eaddr_r[2:0];
      end
    endcase
  end

  always_comb begin
    case (priv_mode_i)
      e_priv_u: priv_fault = ~tlb_u_i;
      e_priv_s: priv_fault = tlb_u_i & ~sum_i;
      default:  priv_fault = 1'b0;
    endcase
  end

  // Without translation the page number passes through untouched
  assign s1_ptag  = translation_en_i ? tlb_ptag_i : s1_eaddr_r[PAGE_OFFSET_W +: PTAG_W];
  assign s1_paddr = {s1_ptag, s1_eaddr_r[PAGE_OFFSET_W-1:0]};

  // Fault priority chain
  assign misaligned = s1_v_r & mis_raw;
  assign bad_addr   = s1_v_r & ~mis_raw & noncanon;
  assign tlb_miss   = s1_v_r & ~mis_raw & ~noncanon & translation_en_i & ~tlb_hit_i;
  assign xlate_ok   = s1_v_r & ~mis_raw & ~noncanon & (~translation_en_i | tlb_hit_i);
  assign perm_fault = xlate_ok & translation_en_i
                      & (priv_fault | (~s1_store & ~tlb_r_i) | (s1_store & (~tlb_w_i | ~tlb_d_i)));
  assign range_fault  = xlate_ok & ~perm_fault & (s1_ptag >= PTAG_W'(RAM_PAGES));
  assign page_fault   = (bad_addr & translation_en_i) | perm_fault;
  assign access_fault = (bad_addr & ~translation_en_i) | range_fault;

  assign s1_flags = {tlb_miss,
                     page_fault & ~s1_store, page_fault & s1_store,
                     access_fault & ~s1_store, access_fault & s1_store,
                     misaligned & ~s1_store, misaligned & s1_store};

  assign ram_v_o     = xlate_ok & ~perm_fault & ~range_fault;
  assign ram_we_o    = ram_v_o & s1_store;
  assign ram_addr_o  = s1_paddr[3 +: RAM_ADDR_W];
  assign ram_be_o    = base_be << s1_eaddr_r[2:0];
  assign ram_wdata_o = s1_wdata_r << {s1_eaddr_r[2:0], 3'b000};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s2_v_r     <= 1'b0;
      s2_flags_r <= '0;
    end else begin
      s2_v_r     <= s1_v_r;
      s2_flags_r <= s1_flags;
    end
  end

  always_ff @(posedge clk_i) begin
    s2_op_r    <= s1_op_r;
    s2_off_r   <= s1_eaddr_r[2:0];
    s2_vaddr_r <= s1_eaddr_r[VADDR_W-1:0];
  end

  // RAM word is back, pick the lane and extend
  assign load_ok = s2_v_r & ~(|s2_flags_r) & ~op_is_store(s2_op_r);
  assign lane    = ram_rdata_i >> {s2_off_r, 3'b000};

  always_comb begin
    case (s2_op_r)
      e_lb:    load_data = {{(DWORD_W-8){lane[7]}}, lane[7:0]};
      e_lh:    load_data = {{(DWORD_W-16){lane[15]}}, lane[15:0]};
      e_lw:    load_data = {{(DWORD_W-32){lane[31]}}, lane[31:0]};
      e_ld:    load_data = lane;
      e_lbu:   load_data = {{(DWORD_W-8){1'b0}}, lane[7:0]};
      e_lhu:   load_data = {{(DWORD_W-16){1'b0}}, lane[15:0]};
      e_lwu:   load_data = {{(DWORD_W-32){1'b0}}, lane[31:0]};
      default: load_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_v_o  <= 1'b0;
      res_flags_r <= '0;
    end else begin
      result_v_o  <= s2_v_r;
      res_flags_r <= s2_flags_r;
    end
  end

  always_ff @(posedge clk_i) begin
    result_data_o  <= load_ok ? load_data : '0;
    result_vaddr_o <= s2_vaddr_r;
  end

  assign {tlb_miss_o,
          load_page_fault_o, store_page_fault_o,
          load_access_fault_o, store_access_fault_o,
          load_misaligned_o, store_misaligned_o} = res_flags_r;

endmodule

// ==== hdl/mem_pkg.sv ====
/*
  Shared widths and encodings for the load/store pipe.
  Effective addresses are canonical only when bits 63:39 copy bit 38.
*/
package mem_pkg;

  localparam int DWORD_W       = 64;
  localparam int VADDR_W       = 39;
  localparam int PAGE_OFFSET_W = 12;
  localparam int VTAG_W        = VADDR_W - PAGE_OFFSET_W;
  localparam int PTAG_W        = 10;

  // 8 KiB scratchpad, two 4 KiB physical pages
  localparam int RAM_WORDS  = 1024;
  localparam int RAM_ADDR_W = 10;
  localparam int RAM_PAGES  = 2;

  localparam int TLB_ELS = 8;

  // Low two bits give log2 of the access size for every opcode
  typedef enum logic [3:0] {
    e_lb  = 4'h0,
    e_lh  = 4'h1,
    e_lw  = 4'h2,
    e_ld  = 4'h3,
    e_lbu = 4'h4,
    e_lhu = 4'h5,
    e_lwu = 4'h6,
    e_sb  = 4'h8,
    e_sh  = 4'h9,
    e_sw  = 4'ha,
    e_sd  = 4'hb
  } mem_op_e;

  typedef enum logic [1:0] {
    e_priv_u = 2'd0,
    e_priv_s = 2'd1,
    e_priv_m = 2'd3
  } priv_mode_e;

  function automatic logic op_is_store(input mem_op_e op);
    return op[3];
  endfunction

  // 0 byte, 1 half, 2 word, 3 double
  function automatic logic [1:0] op_size_log2(input mem_op_e op);
    return op[1:0];
  endfunction

endpackage

// ==== hdl/mem_subsystem_top.sv ====
/*
  Load/store pipe with its data TLB and scratchpad; TLB fills come from outside.
*/
`timescale 1ns/1ns

module mem_subsystem_top
  import mem_pkg::*;
  (input                        clk_i
   , input                      reset_i

   , input                      req_v_i
   , output logic               req_ready_o
   , input mem_op_e             req_op_i
   , input [DWORD_W-1:0]        req_rs1_i
   , input [DWORD_W-1:0]        req_imm_i
   , input [DWORD_W-1:0]        req_rs2_i

   , input                      translation_en_i
   , input priv_mode_e          priv_mode_i
   , input                      sum_i
   , input                      sfence_i

   , input                      tlb_fill_v_i
   , input [VTAG_W-1:0]         tlb_fill_vtag_i
   , input [PTAG_W-1:0]         tlb_fill_ptag_i
   , input                      tlb_fill_r_i
   , input                      tlb_fill_w_i
   , input                      tlb_fill_u_i
   , input                      tlb_fill_d_i

   , output logic               result_v_o
   , output logic [DWORD_W-1:0] result_data_o
   , output logic [VADDR_W-1:0] result_vaddr_o
   , output logic               tlb_miss_o
   , output logic               load_page_fault_o
   , output logic               store_page_fault_o
   , output logic               load_access_fault_o
   , output logic               store_access_fault_o
   , output logic               load_misaligned_o
   , output logic               store_misaligned_o
   );

  logic                  tlb_lookup_v;
  logic [VTAG_W-1:0]     tlb_lookup_vtag;
  logic                  tlb_hit;
  logic [PTAG_W-1:0]     tlb_ptag;
  logic                  tlb_r, tlb_w, tlb_u, tlb_d;

  logic                  ram_v, ram_we;
  logic [RAM_ADDR_W-1:0] ram_addr;
  logic [7:0]            ram_be;
  logic [DWORD_W-1:0]    ram_wdata, ram_rdata;

  mem_pipe pipe
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.req_v_i(req_v_i)
     ,.req_ready_o(req_ready_o)
     ,.req_op_i(req_op_i)
     ,.req_rs1_i(req_rs1_i)
     ,.req_imm_i(req_imm_i)
     ,.req_rs2_i(req_rs2_i)
     ,.tlb_fill_v_i(tlb_fill_v_i)
     ,.translation_en_i(translation_en_i)
     ,.priv_mode_i(priv_mode_i)
     ,.sum_i(sum_i)
     ,.tlb_lookup_v_o(tlb_lookup_v)
     ,.tlb_lookup_vtag_o(tlb_lookup_vtag)
     ,.tlb_hit_i(tlb_hit)
     ,.tlb_ptag_i(tlb_ptag)
     ,.tlb_r_i(tlb_r)
     ,.tlb_w_i(tlb_w)
     ,.tlb_u_i(tlb_u)
     ,.tlb_d_i(tlb_d)
     ,.ram_v_o(ram_v)
     ,.ram_we_o(ram_we)
     ,.ram_addr_o(ram_addr)
     ,.ram_be_o(ram_be)
     ,.ram_wdata_o(ram_wdata)
     ,.ram_rdata_i(ram_rdata)
     ,.result_v_o(result_v_o)
     ,.result_data_o(result_data_o)
     ,.result_vaddr_o(result_vaddr_o)
     ,.tlb_miss_o(tlb_miss_o)
     ,.load_page_fault_o(load_page_fault_o)
     ,.store_page_fault_o(store_page_fault_o)
     ,.load_access_fault_o(load_access_fault_o)
     ,.store_access_fault_o(store_access_fault_o)
     ,.load_misaligned_o(load_misaligned_o)
     ,.store_misaligned_o(store_misaligned_o)
     );

  mem_dtlb #(.els_p(TLB_ELS)) dtlb
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.flush_i(sfence_i)
     ,.lookup_v_i(tlb_lookup_v)
     ,.lookup_vtag_i(tlb_lookup_vtag)
     ,.fill_v_i(tlb_fill_v_i)
     ,.fill_vtag_i(tlb_fill_vtag_i)
     ,.fill_ptag_i(tlb_fill_ptag_i)
     ,.fill_r_i(tlb_fill_r_i)
     ,.fill_w_i(tlb_fill_w_i)
     ,.fill_u_i(tlb_fill_u_i)
     ,.fill_d_i(tlb_fill_d_i)
     ,.hit_o(tlb_hit)
     ,.ptag_o(tlb_ptag)
     ,.r_o(tlb_r)
     ,.w_o(tlb_w)
     ,.u_o(tlb_u)
     ,.d_o(tlb_d)
     );

  mem_data_ram data_ram
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.v_i(ram_v)
     ,.we_i(ram_we)
     ,.addr_i(ram_addr)
     ,.be_i(ram_be)
     ,.wdata_i(ram_wdata)
     ,.rdata_o(ram_rdata)
     );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal --top-module mem_tb -f files.f -o mem_tb_sim \
  && ./obj_dir/mem_tb_sim | tee sim.log \
  || { echo "Build or run failed"; exit 1; }

grep -q "^=== PASS ===$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== verification/mem_tb.sv ====
/*
  Directed testbench for mem_subsystem_top. Expected results come from a scoreboard
  with a word-level memory model and a TLB model. Loads only read words that were stored first.
*/
`timescale 1ns/1ns

module mem_tb
  import mem_pkg::*;
  ();

  // The tests need a few hundred cycles
  localparam int max_cycles_lp = 2000;

  // Bit positions in the flag vector
  localparam int f_miss_lp = 6;
  localparam int f_lpf_lp  = 5;
  localparam int f_spf_lp  = 4;
  localparam int f_laf_lp  = 3;
  localparam int f_saf_lp  = 2;
  localparam int f_lmis_lp = 1;
  localparam int f_smis_lp = 0;

  logic clk = 1'b0;
  logic reset;
  logic req_v, req_ready;
  mem_op_e req_op;
  logic [DWORD_W-1:0] req_rs1, req_imm, req_rs2;
  logic xlate_en, sum, sfence;
  priv_mode_e priv;
  logic fill_v, fill_r, fill_w, fill_u, fill_d;
  logic [VTAG_W-1:0] fill_vtag;
  logic [PTAG_W-1:0] fill_ptag;
  logic res_v;
  logic [DWORD_W-1:0] res_data;
  logic [VADDR_W-1:0] res_vaddr;
  logic miss, lpf, spf, laf, saf, lmis, smis;

  // Keyed by physical word index and by vtag; TLB entry is {ptag, r, w, u, d}
  logic [DWORD_W-1:0] mem_model [longint];
  logic [PTAG_W+3:0]  tlb_model [longint];

  logic [DWORD_W-1:0] exp_data_q [$];
  logic [VADDR_W-1:0] exp_vaddr_q [$];
  logic [6:0]         exp_flags_q [$];
  int                 exp_cycle_q [$];

  int cycle = 0;
  int errors = 0;
  int checks = 0;
  int seed = 32'h0f1c_0620;

  always #10 clk = ~clk;

  mem_subsystem_top uut
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.req_v_i(req_v)
     ,.req_ready_o(req_ready)
     ,.req_op_i(req_op)
     ,.req_rs1_i(req_rs1)
     ,.req_imm_i(req_imm)
     ,.req_rs2_i(req_rs2)
     ,.translation_en_i(xlate_en)
     ,.priv_mode_i(priv)
     ,.sum_i(sum)
     ,.sfence_i(sfence)
     ,.tlb_fill_v_i(fill_v)
     ,.tlb_fill_vtag_i(fill_vtag)
     ,.tlb_fill_ptag_i(fill_ptag)
     ,.tlb_fill_r_i(fill_r)
     ,.tlb_fill_w_i(fill_w)
     ,.tlb_fill_u_i(fill_u)
     ,.tlb_fill_d_i(fill_d)
     ,.result_v_o(res_v)
     ,.result_data_o(res_data)
     ,.result_vaddr_o(res_vaddr)
     ,.tlb_miss_o(miss)
     ,.load_page_fault_o(lpf)
     ,.store_page_fault_o(spf)
     ,.load_access_fault_o(laf)
     ,.store_access_fault_o(saf)
     ,.load_misaligned_o(lmis)
     ,.store_misaligned_o(smis)
     );

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles_lp) begin
      $display("Run timed out after %0d cycles, %0d results outstanding",
               cycle, exp_data_q.size());
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic logic [DWORD_W-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
  endtask

  // Applies one operation to the models and gives its expected data and flags
  task automatic predict_op(input mem_op_e op, input logic [63:0] ea,
                            input logic [63:0] wdata,
                            output logic [63:0] data, output logic [6:0] flags);
    int size;
    int off;
    logic store, perm;
    logic [PTAG_W+3:0] ent;
    logic [PTAG_W-1:0] ptag;
    longint vtag, widx;
    logic [DWORD_W-1:0] word, lane;
    store = op inside {e_sb, e_sh, e_sw, e_sd};
    case (op)
      e_lb, e_lbu, e_sb: size = 1;
      e_lh, e_lhu, e_sh: size = 2;
      e_lw, e_lwu, e_sw: size = 4;
      default:           size = 8;
    endcase
    off = int'(ea[2:0]);
    vtag = longint'(ea[VADDR_W-1:PAGE_OFFSET_W]);
    data = '0;
    flags = '0;
    perm = 1'b0;
    if ((off % size) != 0) begin
      flags[store ? f_smis_lp : f_lmis_lp] = 1'b1;
    end else if (ea[63:VADDR_W-1] != '0 && ea[63:VADDR_W-1] != '1) begin
      if (xlate_en) flags[store ? f_spf_lp : f_lpf_lp] = 1'b1;
      else flags[store ? f_saf_lp : f_laf_lp] = 1'b1;
    end else if (xlate_en && !tlb_model.exists(vtag)) begin
      flags[f_miss_lp] = 1'b1;
    end else begin
      if (xlate_en) begin
        ent  = tlb_model[vtag];
        ptag = ent[PTAG_W+3:4];
        perm = (priv == e_priv_u && !ent[1]) || (priv == e_priv_s && ent[1] && !sum)
               || (!store && !ent[3]) || (store && (!ent[2] || !ent[0]));
      end else begin
        ptag = ea[21:12];
      end
      widx = longint'({ptag, ea[PAGE_OFFSET_W-1:3]});
      word = mem_model.exists(widx) ? mem_model[widx] : '0;
      if (perm) begin
        flags[store ? f_spf_lp : f_lpf_lp] = 1'b1;
      end else if (ptag >= PTAG_W'(RAM_PAGES)) begin
        flags[store ? f_saf_lp : f_laf_lp] = 1'b1;
      end else if (store) begin
        for (int i = 0; i < size; i++) word[8*(off+i) +: 8] = wdata[8*i +: 8];
        mem_model[widx] = word;
      end else begin
        lane = word >> (8 * off);
        case (op)
          e_lb:    data = {{56{lane[7]}}, lane[7:0]};
          e_lh:    data = {{48{lane[15]}}, lane[15:0]};
          e_lw:    data = {{32{lane[31]}}, lane[31:0]};
          e_lbu:   data = {56'h0, lane[7:0]};
          e_lhu:   data = {48'h0, lane[15:0]};
          e_lwu:   data = {32'h0, lane[31:0]};
          default: data = lane;
        endcase
      end
    end
  endtask

  // Holds the request until it is accepted, then records what must come back
  task automatic issue_req(input mem_op_e op, input logic [63:0] rs1, input logic [63:0] imm,
                           input logic [63:0] rs2);
    logic [63:0] data;
    logic [6:0] flags;
    logic done;
    req_v = 1'b1;
    req_op = op;
    req_rs1 = rs1;
    req_imm = imm;
    req_rs2 = rs2;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (req_ready) begin
        predict_op(op, rs1 + imm, rs2, data, flags);
        exp_data_q.push_back(data);
        exp_vaddr_q.push_back((rs1 + imm) & {VADDR_W{1'b1}});
        exp_flags_q.push_back(flags);
        // Accepted at the coming edge, result two edges later
        exp_cycle_q.push_back(cycle + 3);
        done = 1'b1;
      end
      @(posedge clk);
      #2;
    end
    req_v = 1'b0;
  endtask

  task automatic drain_results();
    do @(posedge clk); while (exp_data_q.size() != 0);
    #2;
  endtask

  task automatic fill_tlb(input logic [VTAG_W-1:0] vtag, input logic [PTAG_W-1:0] ptag,
                          input logic r, input logic w, input logic u, input logic d);
    fill_v = 1'b1;
    fill_vtag = vtag;
    fill_ptag = ptag;
    {fill_r, fill_w, fill_u, fill_d} = {r, w, u, d};
    @(negedge clk);
    assert (!req_ready) else report_mismatch("req_ready_o during fill", 64'(req_ready), 64'h0);
    @(posedge clk);
    #2;
    fill_v = 1'b0;
    tlb_model[longint'(vtag)] = {ptag, r, w, u, d};
  endtask

  task automatic flush_tlb();
    sfence = 1'b1;
    @(posedge clk);
    #2;
    sfence = 1'b0;
    tlb_model.delete();
  endtask

  task automatic compare_result();
    logic [DWORD_W-1:0] exp_data;
    logic [VADDR_W-1:0] exp_vaddr;
    logic [6:0]         exp_flags;
    int                 exp_cycle;
    exp_data  = exp_data_q.pop_front();
    exp_vaddr = exp_vaddr_q.pop_front();
    exp_flags = exp_flags_q.pop_front();
    exp_cycle = exp_cycle_q.pop_front();
    assert (cycle == exp_cycle) else begin
      errors++;
      $display("Result for %h came at cycle %0d instead of %0d", exp_vaddr, cycle, exp_cycle);
    end
    assert (res_vaddr == exp_vaddr)
      else report_mismatch("result_vaddr_o", 64'(res_vaddr), 64'(exp_vaddr));
    assert ({miss, lpf, spf, laf, saf, lmis, smis} == exp_flags)
      else report_mismatch("fault flags", 64'({miss, lpf, spf, laf, saf, lmis, smis}),
                           64'(exp_flags));
    assert (res_data == exp_data) else report_mismatch("result_data_o", res_data, exp_data);
  endtask

  always @(negedge clk) begin
    if (!reset) begin
      if (res_v) begin
        checks++;
        assert (exp_data_q.size() != 0) else begin
          errors++;
          $display("A result came out with no request outstanding");
        end
        if (exp_data_q.size() != 0) compare_result();
      end else if (exp_cycle_q.size() != 0) begin
        assert (exp_cycle_q[0] > cycle) else begin
          errors++;
          $display("No result for %h by cycle %0d", exp_vaddr_q[0], exp_cycle_q[0]);
          exp_data_q.delete(0);
          exp_vaddr_q.delete(0);
          exp_flags_q.delete(0);
          exp_cycle_q.delete(0);
        end
      end
    end
  end

  task automatic check_idle();
    @(negedge clk);
    assert (!res_v) else report_mismatch("result_v_o after reset", 64'(res_v), 64'h0);
    assert ({miss, lpf, spf, laf, saf, lmis, smis} == 7'h0)
      else report_mismatch("flags after reset", 64'({miss, lpf, spf, laf, saf, lmis, smis}), 0);
    assert (req_ready) else report_mismatch("req_ready_o after reset", 64'(req_ready), 64'h1);
    @(posedge clk);
    #2;
  endtask

  task automatic test_bare_access();
    logic [DWORD_W-1:0] base;
    xlate_en = 1'b0;
    priv = e_priv_m;
    for (int i = 0; i < 4; i++) begin
      base = 64'(i) * 64'h528;
      issue_req(e_sd, base, 64'h0, rand64());
      drain_results();
      issue_req(e_ld, base, 64'h0, 64'h0);
      drain_results();
    end
    // Partial stores inside one word, each followed by its loads
    base = 64'h1100;
    issue_req(e_sd, base, 64'h0, rand64());
    for (int off = 0; off < 8; off++) begin
      issue_req(e_sb, base, 64'(off), rand64());
      issue_req(e_lb, base, 64'(off), 64'h0);
      issue_req(e_lbu, base, 64'(off), 64'h0);
    end
    for (int off = 0; off < 8; off += 2) begin
      issue_req(e_sh, base, 64'(off), rand64());
      issue_req(e_lh, base, 64'(off), 64'h0);
      issue_req(e_lhu, base, 64'(off), 64'h0);
    end
    for (int off = 0; off < 8; off += 4) begin
      issue_req(e_sw, base, 64'(off), rand64());
      issue_req(e_lw, base, 64'(off), 64'h0);
      issue_req(e_lwu, base, 64'(off), 64'h0);
    end
    // Negative immediate
    issue_req(e_ld, base + 64'h10, 64'hffff_ffff_ffff_fff0, 64'h0);
    drain_results();
  endtask

  task automatic test_back_to_back();
    for (int i = 0; i < 6; i++) issue_req(e_sd, 64'h1800, 64'(8 * i), rand64());
    for (int i = 0; i < 6; i++) issue_req(e_ld, 64'h1800, 64'(8 * i), 64'h0);
    issue_req(e_sd, 64'h1830, 64'h0, rand64());
    issue_req(e_ld, 64'h1830, 64'h0, 64'h0);
    issue_req(e_sw, 64'h1834, 64'h0, rand64());
    issue_req(e_lwu, 64'h1834, 64'h0, 64'h0);
    drain_results();
  endtask

  task automatic test_translation();
    xlate_en = 1'b1;
    priv = e_priv_m;
    issue_req(e_ld, 64'h40010, 64'h0, 64'h0);
    drain_results();
    fill_tlb(27'h40, 10'h1, 1'b1, 1'b1, 1'b0, 1'b1);
    issue_req(e_sd, 64'h40010, 64'h0, rand64());
    issue_req(e_ld, 64'h40010, 64'h0, 64'h0);
    drain_results();
    // Same word through its physical address
    xlate_en = 1'b0;
    issue_req(e_ld, 64'h1010, 64'h0, 64'h0);
    drain_results();
    xlate_en = 1'b1;
    flush_tlb();
    issue_req(e_ld, 64'h40010, 64'h0, 64'h0);
    drain_results();
    // Request stays valid through the fill cycle
    req_v = 1'b1;
    req_op = e_ld;
    req_rs1 = 64'h40010;
    req_imm = 64'h0;
    fill_tlb(27'h40, 10'h1, 1'b1, 1'b1, 1'b0, 1'b1);
    issue_req(e_ld, 64'h40010, 64'h0, 64'h0);
    drain_results();
  endtask

  task automatic test_page_faults();
    xlate_en = 1'b0;
    priv = e_priv_m;
    issue_req(e_sd, 64'h0040, 64'h0, rand64());
    issue_req(e_sd, 64'h1008, 64'h0, rand64());
    drain_results();
    xlate_en = 1'b1;
    fill_tlb(27'h41, 10'h0, 1'b1, 1'b1, 1'b0, 1'b1);
    fill_tlb(27'h42, 10'h0, 1'b1, 1'b1, 1'b1, 1'b1);
    fill_tlb(27'h43, 10'h1, 1'b1, 1'b0, 1'b0, 1'b1);
    fill_tlb(27'h44, 10'h1, 1'b1, 1'b1, 1'b0, 1'b0);
    priv = e_priv_u;
    issue_req(e_ld, 64'h41040, 64'h0, 64'h0);
    issue_req(e_ld, 64'h42040, 64'h0, 64'h0);
    drain_results();
    priv = e_priv_s;
    issue_req(e_ld, 64'h42040, 64'h0, 64'h0);
    issue_req(e_sd, 64'h42040, 64'h0, rand64());
    drain_results();
    sum = 1'b1;
    issue_req(e_ld, 64'h42040, 64'h0, 64'h0);
    drain_results();
    sum = 1'b0;
    priv = e_priv_m;
    issue_req(e_sd, 64'h43008, 64'h0, rand64());
    issue_req(e_sh, 64'h44008, 64'h0, rand64());
    issue_req(e_ld, 64'h43008, 64'h0, 64'h0);
    issue_req(e_ld, 64'h0000_0080_0000_0000, 64'h0, 64'h0);
    issue_req(e_sd, 64'hffff_ff00_0000_0000, 64'h0, rand64());
    // Canonical but never filled
    issue_req(e_ld, 64'hffff_ffc0_0000_0000, 64'h0, 64'h0);
    drain_results();
  endtask

  task automatic test_access_faults();
    xlate_en = 1'b0;
    priv = e_priv_m;
    issue_req(e_sd, 64'h0200, 64'h0, rand64());
    issue_req(e_ld, 64'h2000, 64'h0, 64'h0);
    // Page 2 aliases onto the same RAM word as 0x200
    issue_req(e_sd, 64'h2200, 64'h0, rand64());
    issue_req(e_sd, 64'h3ff200, 64'h0, rand64());
    issue_req(e_ld, 64'h0000_0080_0000_0000, 64'h0, 64'h0);
    issue_req(e_lw, 64'h0200, 64'h2, 64'h0);
    issue_req(e_sd, 64'h0200, 64'h4, rand64());
    issue_req(e_lh, 64'h0201, 64'h0, 64'h0);
    issue_req(e_ld, 64'h0200, 64'h0, 64'h0);
    drain_results();
    xlate_en = 1'b1;
    fill_tlb(27'h45, 10'h3fe, 1'b1, 1'b1, 1'b1, 1'b1);
    issue_req(e_ld, 64'h45200, 64'h0, 64'h0);
    issue_req(e_sw, 64'h45204, 64'h0, rand64());
    drain_results();
    xlate_en = 1'b0;
    issue_req(e_ld, 64'h0200, 64'h0, 64'h0);
    drain_results();
  endtask

  initial begin
    reset = 1'b1;
    req_v = 1'b0;
    req_op = e_ld;
    req_rs1 = '0;
    req_imm = '0;
    req_rs2 = '0;
    xlate_en = 1'b0;
    priv = e_priv_m;
    sum = 1'b0;
    sfence = 1'b0;
    fill_v = 1'b0;
    fill_vtag = '0;
    fill_ptag = '0;
    {fill_r, fill_w, fill_u, fill_d} = 4'h0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    check_idle();
    test_bare_access();
    test_back_to_back();
    test_translation();
    test_page_faults();
    test_access_faults();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
